// File: rtl/vlsu_pkg.sv
// Vector load/store unit package
// Widths, operation and element-width codes, the instruction struct and
// the byte-lane helpers shared by both engines

package vlsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ELEN           = 32;
  localparam int unsigned ELENB          = ELEN / 8;
  localparam int unsigned VLEN           = 256;
  localparam int unsigned WORDS_PER_VREG = VLEN / ELEN;
  localparam int unsigned NR_VREGS       = 32;

  // Register number times WORDS_PER_VREG plus word index
  typedef logic [$clog2(NR_VREGS*WORDS_PER_VREG)-1:0] vrf_addr_t;

  typedef logic [$clog2(VLEN/8):0] vl_t;
  typedef logic [$clog2(VLEN/8):0] vbytes_t;
  typedef logic [ELEN-1:0]         elen_t;
  typedef logic [ELENB-1:0]        strb_t;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  typedef enum logic [1:0] {
    VLE  = 2'd0,
    VSE  = 2'd1,
    VLSE = 2'd2,
    VSSE = 2'd3
  } vlsu_op_e;

  typedef struct packed {
    vlsu_op_e    op;
    logic [4:0]  vd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    vl_t         vl;
    vsew_e       vsew;
  } vlsu_req_t;

  // Rotate a word towards higher byte lanes
  function automatic elen_t rot_bytes(elen_t data, logic [1:0] lanes);
    logic [2*ELEN-1:0] wide;
    wide = {data, data} << (8 * lanes);
    return wide[2*ELEN-1:ELEN];
  endfunction

  // nbytes ones starting at lane shift
  function automatic strb_t lane_mask(vbytes_t nbytes, logic [1:0] shift);
    logic [2*ELENB-1:0] ones;
    ones = ((2*ELENB)'(1) << nbytes) - 1'b1;
    return strb_t'(ones << shift);
  endfunction

endpackage

// File: rtl/vlsu_rob_if.sv
// Reorder buffer interface
// Joins the buffer to the memory-side and VRF-side engines

`timescale 1ns/100ps

interface vlsu_rob_if #(
  parameter int unsigned NR_OUTSTANDING = 8
) ();

  import vlsu_pkg::*;

  // Requests from the memory side
  logic                              mem_alloc;
  logic                              mem_push;
  logic [$clog2(NR_OUTSTANDING)-1:0] mem_push_id;
  elen_t                             mem_push_data;
  logic                              mem_pop;

  // Requests from the VRF side, pushes land on next_id
  logic                              vrf_alloc;
  logic                              vrf_push;
  elen_t                             vrf_push_data;
  logic                              vrf_pop;

  // Buffer state
  logic [$clog2(NR_OUTSTANDING)-1:0] next_id;
  logic                              full;
  logic                              empty;
  logic                              head_valid;
  elen_t                             head_data;
  logic [$clog2(NR_OUTSTANDING)-1:0] head_id;

  modport rob (
    input  mem_alloc, mem_push, mem_push_id, mem_push_data, mem_pop,
    input  vrf_alloc, vrf_push, vrf_push_data, vrf_pop,
    output next_id, full, empty, head_valid, head_data, head_id
  );

  modport mem_side (
    output mem_alloc, mem_push, mem_push_id, mem_push_data, mem_pop,
    input  next_id, full, empty, head_valid, head_data, head_id
  );

  modport vrf_side (
    output vrf_alloc, vrf_push, vrf_push_data, vrf_pop,
    input  next_id, full, empty, head_valid, head_data, head_id
  );

endinterface

// File: rtl/vlsu_ctrl.sv
// Load/store instruction controller
// Takes one instruction, turns its vl into a byte count and holds it
// until both engines are idle, then flags completion

`timescale 1ns/100ps

module vlsu_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  vlsu_pkg::vlsu_req_t req_i,
  input  logic                mem_busy_i,
  input  logic                vrf_busy_i,
  output vlsu_pkg::vlsu_req_t cmd_o,
  output logic                cmd_valid_o,
  output logic                done_o
);

  import vlsu_pkg::*;

  vlsu_req_t cmd_q;
  vl_t       vl_bytes;
  logic      cmd_valid_q;
  logic      done_q;
  logic      accept;
  logic      idle;

  assign req_ready_o = ~cmd_valid_q;
  assign accept      = req_valid_i & req_ready_o;
  assign idle        = ~mem_busy_i & ~vrf_busy_i;

  // Element count to byte count
  always_comb begin
    case (req_i.vsew)
      EW_16:   vl_bytes = req_i.vl << 1;
      EW_32:   vl_bytes = req_i.vl << 2;
      default: vl_bytes = req_i.vl;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q    <= req_i;
      cmd_q.vl <= vl_bytes;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_valid_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        cmd_valid_q <= 1'b1;
      end else if (cmd_valid_q && idle) begin
        // Zero-length instructions retire silently
        cmd_valid_q <= 1'b0;
        done_q      <= (cmd_q.vl != '0);
      end
    end
  end

  assign cmd_o       = cmd_q;
  assign cmd_valid_o = cmd_valid_q;
  assign done_o      = done_q;

endmodule

// File: rtl/vlsu_byte_counter.sv
// Byte progress counter for one side of the unit
// Offers one element per step in strided mode, up to a word otherwise

`timescale 1ns/100ps

module vlsu_byte_counter (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              clear_i,
  input  logic              en_i,
  input  vlsu_pkg::vbytes_t total_i,
  input  logic              single_i,
  input  vlsu_pkg::vbytes_t elem_bytes_i,
  output vlsu_pkg::vbytes_t pos_o,
  output vlsu_pkg::vbytes_t step_o,
  output logic              valid_o,
  output logic              last_o
);

  import vlsu_pkg::*;

  vbytes_t pos_q;
  vbytes_t remaining;
  vbytes_t max_step;

  assign remaining = total_i - pos_q;
  assign max_step  = single_i ? elem_bytes_i : vbytes_t'(ELENB);

  // Compare rather than test remaining, total drops to zero when idle
  assign valid_o = pos_q < total_i;
  assign last_o  = valid_o & (remaining <= max_step);
  assign step_o  = (last_o && !single_i) ? remaining : max_step;
  assign pos_o   = pos_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pos_q <= '0;
    end else if (clear_i) begin
      pos_q <= '0;
    end else if (en_i) begin
      pos_q <= pos_q + step_o;
    end
  end

endmodule

// File: rtl/vlsu_rob.sv
// Reorder buffer between the memory port and the VRF
// Ids are handed out in order, data lands at any allocated id and
// leaves in allocation order

`timescale 1ns/100ps

module vlsu_rob #(
  parameter int unsigned NR_OUTSTANDING = 8
) (
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     clear_i,
  vlsu_rob_if.rob rob
);

  import vlsu_pkg::*;

  localparam int unsigned IdWidth = $clog2(NR_OUTSTANDING);

  // One extra pointer bit tells full from empty
  logic [IdWidth:0]          wr_ptr_q;
  logic [IdWidth:0]          rd_ptr_q;
  logic [IdWidth:0]          fill;
  logic [NR_OUTSTANDING-1:0] valid_q;
  elen_t                     data_q [NR_OUTSTANDING];
  logic [IdWidth-1:0]        rd_idx;
  logic [IdWidth-1:0]        push_id;
  elen_t                     push_data;
  logic                      alloc;
  logic                      push;
  logic                      pop;

  // Only one side is active per direction, so a plain merge suffices
  assign alloc     = rob.mem_alloc | rob.vrf_alloc;
  assign push      = rob.mem_push | rob.vrf_push;
  assign pop       = rob.mem_pop | rob.vrf_pop;
  assign push_id   = rob.mem_push ? rob.mem_push_id : rob.next_id;
  assign push_data = rob.mem_push ? rob.mem_push_data : rob.vrf_push_data;

  assign fill   = wr_ptr_q - rd_ptr_q;
  assign rd_idx = rd_ptr_q[IdWidth-1:0];

  assign rob.next_id    = wr_ptr_q[IdWidth-1:0];
  assign rob.full       = fill == (IdWidth+1)'(NR_OUTSTANDING);
  assign rob.empty      = fill == '0;
  assign rob.head_valid = valid_q[rd_idx];
  assign rob.head_data  = data_q[rd_idx];
  assign rob.head_id    = rd_idx;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      valid_q  <= '0;
    end else begin
      if (alloc) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q        <= rd_ptr_q + 1'b1;
        valid_q[rd_idx] <= 1'b0;
      end
      if (push) begin
        valid_q[push_id] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q[push_id] <= push_data;
    end
  end

endmodule

// File: rtl/vlsu_mem_issue.sv
// Memory-side engine
// Builds word addresses and strobes, issues loads with buffer ids and
// stores from the buffer head, and pushes returning load data

`timescale 1ns/100ps

module vlsu_mem_issue #(
  parameter int unsigned NR_OUTSTANDING = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  vlsu_pkg::vlsu_req_t               cmd_i,
  input  logic                              cmd_valid_i,
  input  logic                              start_i,
  output logic                              mem_valid_o,
  input  logic                              mem_ready_i,
  output logic [31:0]                       mem_addr_o,
  output logic                              mem_we_o,
  output vlsu_pkg::strb_t                   mem_strb_o,
  output vlsu_pkg::elen_t                   mem_wdata_o,
  output logic [$clog2(NR_OUTSTANDING)-1:0] mem_id_o,
  input  logic                              mem_rvalid_i,
  input  logic [$clog2(NR_OUTSTANDING)-1:0] mem_rid_i,
  input  vlsu_pkg::elen_t                   mem_rdata_i,
  vlsu_rob_if.mem_side                      rob,
  output logic                              busy_o
);

  import vlsu_pkg::*;

  logic        is_load;
  logic        is_strided;
  logic        handshake;
  logic        cnt_valid;
  logic        cnt_last;
  vbytes_t     total;
  vbytes_t     elem_bytes;
  vbytes_t     pos;
  vbytes_t     step;
  logic [31:0] addr;

  assign is_load    = (cmd_i.op == VLE) || (cmd_i.op == VLSE);
  assign is_strided = (cmd_i.op == VLSE) || (cmd_i.op == VSSE);
  assign total      = cmd_valid_i ? vbytes_t'(cmd_i.vl) : '0;
  assign elem_bytes = vbytes_t'(1) << cmd_i.vsew;

  vlsu_byte_counter u_mem_counter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (start_i),
    .en_i        (handshake),
    .total_i     (total),
    .single_i    (is_strided),
    .elem_bytes_i(elem_bytes),
    .pos_o       (pos),
    .step_o      (step),
    .valid_o     (cnt_valid),
    .last_o      (cnt_last)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Address and strobes
  ////////////////////////////////////////////////////////////////////////////

  // Strided: element index times stride, unit stride: byte position
  assign addr = is_strided ? cmd_i.rs1 + 32'(pos >> cmd_i.vsew) * cmd_i.rs2
                           : cmd_i.rs1 + 32'(pos);

  assign mem_addr_o = {addr[31:2], 2'b00};
  assign mem_we_o   = ~is_load;

  // Only the final unit-stride word is partial
  assign mem_strb_o = is_strided ? lane_mask(elem_bytes, addr[1:0]) :
                      cnt_last   ? lane_mask(step, 2'b00) : '1;

  ////////////////////////////////////////////////////////////////////////////
  // Issue and buffer traffic
  ////////////////////////////////////////////////////////////////////////////

  // Loads wait for a free id, stores for data at the head
  assign mem_valid_o = cnt_valid & (is_load ? ~rob.full : rob.head_valid);
  assign handshake   = mem_valid_o & mem_ready_i;
  assign mem_id_o    = is_load ? rob.next_id : rob.head_id;

  // Store element sits in lane 0, move it to its address lane
  assign mem_wdata_o = rot_bytes(rob.head_data, addr[1:0]);

  assign rob.mem_alloc     = handshake & is_load;
  assign rob.mem_pop       = handshake & ~is_load;
  assign rob.mem_push      = mem_rvalid_i & is_load;
  assign rob.mem_push_id   = mem_rid_i;
  assign rob.mem_push_data = mem_rdata_i;

  // Outstanding loads keep this side busy
  assign busy_o = cnt_valid | ~rob.empty;

endmodule

// File: rtl/vlsu_vrf_port.sv
// VRF-side engine
// Writes load data from the buffer head into the register lanes and
// reads store data from the VRF into the buffer

`timescale 1ns/100ps

module vlsu_vrf_port (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  vlsu_pkg::vlsu_req_t cmd_i,
  input  logic                cmd_valid_i,
  input  logic                start_i,
  output logic                vrf_we_o,
  input  logic                vrf_wack_i,
  output vlsu_pkg::vrf_addr_t vrf_waddr_o,
  output vlsu_pkg::elen_t     vrf_wdata_o,
  output vlsu_pkg::strb_t     vrf_wbe_o,
  output logic                vrf_re_o,
  output vlsu_pkg::vrf_addr_t vrf_raddr_o,
  input  vlsu_pkg::elen_t     vrf_rdata_i,
  input  logic                vrf_rvalid_i,
  vlsu_rob_if.vrf_side        rob,
  output logic                busy_o
);

  import vlsu_pkg::*;

  logic      is_load;
  logic      is_strided;
  logic      cnt_en;
  logic      cnt_valid;
  logic      cnt_last;
  vbytes_t   total;
  vbytes_t   elem_bytes;
  vbytes_t   pos;
  vbytes_t   step;
  vrf_addr_t word_addr;
  logic [1:0] reg_lane;
  logic [1:0] mem_lane;

  assign is_load    = (cmd_i.op == VLE) || (cmd_i.op == VLSE);
  assign is_strided = (cmd_i.op == VLSE) || (cmd_i.op == VSSE);
  assign total      = cmd_valid_i ? vbytes_t'(cmd_i.vl) : '0;
  assign elem_bytes = vbytes_t'(1) << cmd_i.vsew;

  vlsu_byte_counter u_vrf_counter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (start_i),
    .en_i        (cnt_en),
    .total_i     (total),
    .single_i    (is_strided),
    .elem_bytes_i(elem_bytes),
    .pos_o       (pos),
    .step_o      (step),
    .valid_o     (cnt_valid),
    .last_o      (cnt_last)
  );

  assign word_addr = vrf_addr_t'(cmd_i.vd * WORDS_PER_VREG + pos / ELENB);
  assign reg_lane  = pos[1:0];

  // Lane the element had in memory, low bits of rs1 + e * stride
  assign mem_lane = is_strided ?
                    2'(cmd_i.rs1[1:0] + (pos >> cmd_i.vsew) * cmd_i.rs2[1:0]) : 2'b00;

  ////////////////////////////////////////////////////////////////////////////
  // Load write-back
  ////////////////////////////////////////////////////////////////////////////

  assign vrf_we_o    = cnt_valid & is_load & rob.head_valid;
  assign vrf_waddr_o = word_addr;
  assign vrf_wdata_o = rot_bytes(rob.head_data, reg_lane - mem_lane);
  assign vrf_wbe_o   = is_strided ? lane_mask(elem_bytes, reg_lane) :
                       cnt_last   ? lane_mask(step, 2'b00) : '1;

  assign rob.vrf_pop = vrf_we_o & vrf_wack_i;

  ////////////////////////////////////////////////////////////////////////////
  // Store read
  ////////////////////////////////////////////////////////////////////////////

  // Hold off while the buffer has no free id
  assign vrf_re_o    = cnt_valid & ~is_load & ~rob.full;
  assign vrf_raddr_o = word_addr;

  // Strided elements go down to lane 0
  assign rob.vrf_alloc     = vrf_re_o & vrf_rvalid_i;
  assign rob.vrf_push      = vrf_re_o & vrf_rvalid_i;
  assign rob.vrf_push_data = rot_bytes(vrf_rdata_i, 2'(2'd0 - reg_lane));

  assign cnt_en = rob.vrf_pop | rob.vrf_push;
  assign busy_o = cnt_valid;

endmodule

// File: rtl/vlsu_top.sv
// Vector load/store unit top level
// Controller, reorder buffer and the memory-side and VRF-side engines

`timescale 1ns/100ps

module vlsu_top #(
  parameter int unsigned NR_OUTSTANDING = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Instruction request
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  vlsu_pkg::vlsu_op_e                req_op_i,
  input  logic [4:0]                        req_vd_i,
  input  logic [31:0]                       req_rs1_i,
  input  logic [31:0]                       req_rs2_i,
  input  vlsu_pkg::vl_t                     req_vl_i,
  input  vlsu_pkg::vsew_e                   req_vsew_i,
  // Memory request and result
  output logic                              mem_valid_o,
  input  logic                              mem_ready_i,
  output logic [31:0]                       mem_addr_o,
  output logic                              mem_we_o,
  output vlsu_pkg::strb_t                   mem_strb_o,
  output vlsu_pkg::elen_t                   mem_wdata_o,
  output logic [$clog2(NR_OUTSTANDING)-1:0] mem_id_o,
  input  logic                              mem_rvalid_i,
  input  logic [$clog2(NR_OUTSTANDING)-1:0] mem_rid_i,
  input  vlsu_pkg::elen_t                   mem_rdata_i,
  // VRF
  output logic                              vrf_we_o,
  input  logic                              vrf_wack_i,
  output vlsu_pkg::vrf_addr_t               vrf_waddr_o,
  output vlsu_pkg::elen_t                   vrf_wdata_o,
  output vlsu_pkg::strb_t                   vrf_wbe_o,
  output logic                              vrf_re_o,
  output vlsu_pkg::vrf_addr_t               vrf_raddr_o,
  input  vlsu_pkg::elen_t                   vrf_rdata_i,
  input  logic                              vrf_rvalid_i,
  output logic                              done_o
);

  import vlsu_pkg::*;

  vlsu_req_t req;
  vlsu_req_t cmd;
  logic      cmd_valid;
  logic      start;
  logic      mem_busy;
  logic      vrf_busy;

  assign req = '{op: req_op_i, vd: req_vd_i, rs1: req_rs1_i, rs2: req_rs2_i,
                 vl: req_vl_i, vsew: req_vsew_i};

  // Acceptance clears the buffer and both counters
  assign start = req_valid_i & req_ready_o;

  vlsu_rob_if #(.NR_OUTSTANDING(NR_OUTSTANDING)) u_rob_if ();

  vlsu_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_i      (req),
    .mem_busy_i (mem_busy),
    .vrf_busy_i (vrf_busy),
    .cmd_o      (cmd),
    .cmd_valid_o(cmd_valid),
    .done_o     (done_o)
  );

  vlsu_rob #(.NR_OUTSTANDING(NR_OUTSTANDING)) u_rob (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .clear_i(start),
    .rob    (u_rob_if.rob)
  );

  vlsu_mem_issue #(.NR_OUTSTANDING(NR_OUTSTANDING)) u_mem_issue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (cmd),
    .cmd_valid_i (cmd_valid),
    .start_i     (start),
    .mem_valid_o (mem_valid_o),
    .mem_ready_i (mem_ready_i),
    .mem_addr_o  (mem_addr_o),
    .mem_we_o    (mem_we_o),
    .mem_strb_o  (mem_strb_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_id_o    (mem_id_o),
    .mem_rvalid_i(mem_rvalid_i),
    .mem_rid_i   (mem_rid_i),
    .mem_rdata_i (mem_rdata_i),
    .rob         (u_rob_if.mem_side),
    .busy_o      (mem_busy)
  );

  vlsu_vrf_port u_vrf_port (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (cmd),
    .cmd_valid_i (cmd_valid),
    .start_i     (start),
    .vrf_we_o    (vrf_we_o),
    .vrf_wack_i  (vrf_wack_i),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .vrf_re_o    (vrf_re_o),
    .vrf_raddr_o (vrf_raddr_o),
    .vrf_rdata_i (vrf_rdata_i),
    .vrf_rvalid_i(vrf_rvalid_i),
    .rob         (u_rob_if.vrf_side),
    .busy_o      (vrf_busy)
  );

endmodule

// File: bench/vlsu_chk.sv
// Handshake checks for the vector load/store unit
// Bound into the top level, watches the memory, VRF and done signals

`timescale 1ns/100ps

module vlsu_chk #(
  parameter int unsigned NR_OUTSTANDING = 8
) (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic                              req_ready_o,
  input logic                              mem_valid_o,
  input logic                              mem_ready_i,
  input logic [31:0]                       mem_addr_o,
  input logic                              mem_we_o,
  input vlsu_pkg::strb_t                   mem_strb_o,
  input vlsu_pkg::elen_t                   mem_wdata_o,
  input logic [$clog2(NR_OUTSTANDING)-1:0] mem_id_o,
  input logic                              vrf_we_o,
  input logic                              vrf_re_o,
  input logic                              done_o
);

  // Stalled request holds, write data only matters for stores
  mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o) &&
      $stable(mem_we_o) && $stable(mem_strb_o) && $stable(mem_id_o) &&
      (!mem_we_o || $stable(mem_wdata_o)))
    else $error("memory request changed while mem_ready_i was low");

  vrf_rd_wr_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(vrf_re_o && vrf_we_o))
    else $error("VRF read and write active in the same cycle");

  done_when_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |-> req_ready_o)
    else $error("done_o high while req_ready_o low");

endmodule

bind vlsu_top vlsu_chk #(.NR_OUTSTANDING(NR_OUTSTANDING)) u_vlsu_chk (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .req_ready_o(req_ready_o),
  .mem_valid_o(mem_valid_o),
  .mem_ready_i(mem_ready_i),
  .mem_addr_o (mem_addr_o),
  .mem_we_o   (mem_we_o),
  .mem_strb_o (mem_strb_o),
  .mem_wdata_o(mem_wdata_o),
  .mem_id_o   (mem_id_o),
  .vrf_we_o   (vrf_we_o),
  .vrf_re_o   (vrf_re_o),
  .done_o     (done_o)
);

// File: bench/tb_vlsu.sv
// Directed testbench for the vector load/store unit
// Byte memory with random stalls and out-of-order returns, word VRF,
// one task per test

`timescale 1ns/100ps

module tb_vlsu;

  import vlsu_pkg::*;

  localparam int unsigned NR_OUT = 8;
  localparam int unsigned ID_W   = $clog2(NR_OUT);
  // Eight instructions, at most about 500 cycles each under heavy stalls
  localparam int CYCLE_LIMIT = 8 * 500;

  logic            clk_i = 1'b0;
  logic            rst_n_i;
  logic            req_valid_i;
  logic            req_ready_o;
  vlsu_op_e        req_op_i;
  logic [4:0]      req_vd_i;
  logic [31:0]     req_rs1_i;
  logic [31:0]     req_rs2_i;
  vl_t             req_vl_i;
  vsew_e           req_vsew_i;
  logic            mem_valid_o;
  logic            mem_ready_i  = 1'b0;
  logic [31:0]     mem_addr_o;
  logic            mem_we_o;
  strb_t           mem_strb_o;
  elen_t           mem_wdata_o;
  logic [ID_W-1:0] mem_id_o;
  logic            mem_rvalid_i = 1'b0;
  logic [ID_W-1:0] mem_rid_i    = '0;
  elen_t           mem_rdata_i  = '0;
  logic            vrf_we_o;
  logic            vrf_wack_i   = 1'b0;
  vrf_addr_t       vrf_waddr_o;
  elen_t           vrf_wdata_o;
  strb_t           vrf_wbe_o;
  logic            vrf_re_o;
  vrf_addr_t       vrf_raddr_o;
  elen_t           vrf_rdata_i;
  logic            vrf_rvalid_i;
  logic            done_o;

  logic [7:0]  mem [4096];
  logic [7:0]  exp_mem [4096];
  elen_t       vrf [256];
  elen_t       exp_vrf [256];
  int unsigned pool_id [$];
  logic [31:0] pool_addr [$];
  logic [31:0] model_rng = 32'h42eb;
  logic [31:0] stim_rng  = 32'h42eb;
  logic        heavy     = 1'b0;
  int          errors    = 0;
  int          done_cnt  = 0;
  int          valid_cnt = 0;
  int          cycle_cnt = 0;

  always #5 clk_i = ~clk_i;

  vlsu_top #(.NR_OUTSTANDING(NR_OUT)) u_vlsu_top (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
    .req_vd_i(req_vd_i), .req_rs1_i(req_rs1_i), .req_rs2_i(req_rs2_i),
    .req_vl_i(req_vl_i), .req_vsew_i(req_vsew_i),
    .mem_valid_o(mem_valid_o), .mem_ready_i(mem_ready_i), .mem_addr_o(mem_addr_o),
    .mem_we_o(mem_we_o), .mem_strb_o(mem_strb_o), .mem_wdata_o(mem_wdata_o),
    .mem_id_o(mem_id_o), .mem_rvalid_i(mem_rvalid_i), .mem_rid_i(mem_rid_i),
    .mem_rdata_i(mem_rdata_i),
    .vrf_we_o(vrf_we_o), .vrf_wack_i(vrf_wack_i), .vrf_waddr_o(vrf_waddr_o),
    .vrf_wdata_o(vrf_wdata_o), .vrf_wbe_o(vrf_wbe_o), .vrf_re_o(vrf_re_o),
    .vrf_raddr_o(vrf_raddr_o), .vrf_rdata_i(vrf_rdata_i),
    .vrf_rvalid_i(vrf_rvalid_i), .done_o(done_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // VRF reads answer in the same cycle
  assign vrf_rdata_i  = vrf[vrf_raddr_o];
  assign vrf_rvalid_i = vrf_re_o;

  ////////////////////////////////////////////////////////////////////////////
  // Memory and VRF models
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : models
    logic [31:0] rnd;
    logic [31:0] a;
    elen_t       word;
    int          k;
    model_rng = xorshift32(model_rng);
    rnd       = model_rng;
    if (mem_valid_o) valid_cnt++;
    if (done_o) done_cnt++;
    if (mem_valid_o && mem_ready_i) begin
      if (mem_we_o) begin
        for (k = 0; k < 4; k++)
          if (mem_strb_o[k]) mem[12'(mem_addr_o + k)] <= mem_wdata_o[8*k +: 8];
      end else begin
        pool_id.push_back(int'(mem_id_o));
        pool_addr.push_back(mem_addr_o);
      end
    end
    // Random pick from the pool gives out-of-order results
    mem_rvalid_i <= 1'b0;
    if (pool_id.size() != 0 && rnd[3:2] != 2'b00) begin
      k = int'(rnd[31:16]) % pool_id.size();
      a = pool_addr[k];
      for (int i = 0; i < 4; i++) word[8*i +: 8] = mem[12'(a + i)];
      mem_rvalid_i <= 1'b1;
      mem_rid_i    <= ID_W'(pool_id[k]);
      mem_rdata_i  <= word;
      pool_id.delete(k);
      pool_addr.delete(k);
    end
    if (vrf_we_o && vrf_wack_i) begin
      for (k = 0; k < 4; k++)
        if (vrf_wbe_o[k]) vrf[vrf_waddr_o][8*k +: 8] <= vrf_wdata_o[8*k +: 8];
    end
    mem_ready_i <= heavy ? (rnd[0] & rnd[1]) : (rnd[0] | rnd[1]);
    vrf_wack_i  <= heavy ? (rnd[4] & rnd[5]) : (rnd[4] | rnd[5]);
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Expected models, byte p of the instruction at rs1 + e * stride
  task automatic build_expected(input vlsu_op_e op, input logic [4:0] vd,
                                input logic [31:0] rs1, input logic [31:0] rs2,
                                input vl_t vl, input vsew_e sew);
    int         esz;
    int         stride;
    int         e;
    int         b;
    int         p;
    int         w;
    logic [11:0] a;
    exp_mem = mem;
    exp_vrf = vrf;
    esz     = 1 << sew;
    stride  = (op == VLSE || op == VSSE) ? int'(rs2) : esz;
    for (e = 0; e < int'(vl); e++) begin
      for (b = 0; b < esz; b++) begin
        p = e * esz + b;
        a = 12'(rs1 + e * stride + b);
        w = int'(vd) * WORDS_PER_VREG + p / ELENB;
        if (op == VLE || op == VLSE) exp_vrf[w][8*(p%4) +: 8] = mem[a];
        else exp_mem[a] = vrf[w][8*(p%4) +: 8];
      end
    end
  endtask

  task automatic issue(input vlsu_op_e op, input logic [4:0] vd, input logic [31:0] rs1,
                       input logic [31:0] rs2, input vl_t vl, input vsew_e sew);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_vd_i    <= vd;
    req_rs1_i   <= rs1;
    req_rs2_i   <= rs2;
    req_vl_i    <= vl;
    req_vsew_i  <= sew;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic run_instr(input vlsu_op_e op, input logic [4:0] vd, input logic [31:0] rs1,
                           input logic [31:0] rs2, input vl_t vl, input vsew_e sew);
    build_expected(op, vd, rs1, rs2, vl, sew);
    issue(op, vd, rs1, rs2, vl, sew);
    do @(posedge clk_i); while (!done_o);
    repeat (4) @(posedge clk_i);
  endtask

  task automatic check_models(input string name);
    int i;
    for (i = 0; i < 4096; i++) begin
      if (mem[i] !== exp_mem[i]) begin
        $display("** Error %s: mem[%03h] expected %02h, actual %02h", name, i, exp_mem[i],
                 mem[i]);
        errors++;
      end
    end
    for (i = 0; i < 256; i++) begin
      if (vrf[i] !== exp_vrf[i]) begin
        $display("** Error %s: vrf[%02h] expected %08h, actual %08h", name, i, exp_vrf[i],
                 vrf[i]);
        errors++;
      end
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp,
                             input int act);
    if (exp != act) begin
      $display("** Error %s: %s expected %0d, actual %0d", name, what, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_unit_load();
    int d0;
    d0 = done_cnt;
    run_instr(VLE, 5'd1, 32'h040, 32'h0, 6'd8, EW_32);
    check_models("unit_load");
    check_count("unit_load", "done pulses", d0 + 1, done_cnt);
  endtask

  task automatic test_unit_store_partial();
    run_instr(VSE, 5'd3, 32'h100, 32'h0, 6'd7, EW_8);
    check_models("unit_store_partial");
  endtask

  task automatic test_strided_load();
    run_instr(VLSE, 5'd5, 32'h200, 32'd6, 6'd5, EW_16);
    check_models("strided_load");
  endtask

  task automatic test_strided_store();
    logic [31:0] stride;
    stim_rng = xorshift32(stim_rng);
    stride   = ((stim_rng % 8) + 1) * 4;
    run_instr(VSSE, 5'd7, 32'h400, stride, 6'd8, EW_32);
    check_models("strided_store");
  endtask

  task automatic test_backpressure();
    int d0;
    d0 = done_cnt;
    heavy <= 1'b1;
    run_instr(VLE, 5'd9, 32'h080, 32'h0, 6'd8, EW_32);
    check_models("backpressure");
    run_instr(VLSE, 5'd10, 32'h301, 32'd3, 6'd12, EW_8);
    check_models("backpressure");
    heavy <= 1'b0;
    check_count("backpressure", "done pulses", d0 + 2, done_cnt);
  endtask

  task automatic test_zero_vl();
    int d0;
    int v0;
    d0 = done_cnt;
    v0 = valid_cnt;
    build_expected(VLE, 5'd2, 32'h700, 32'h0, 6'd0, EW_32);
    issue(VLE, 5'd2, 32'h700, 32'h0, 6'd0, EW_32);
    repeat (4) @(posedge clk_i);
    check_count("zero_vl", "memory request cycles", v0, valid_cnt);
    check_count("zero_vl", "done pulses", d0, done_cnt);
    if (!req_ready_o) begin
      $display("zero_vl: req_ready_o stayed low after a zero-length request");
      errors++;
    end
    check_models("zero_vl");
    run_instr(VSE, 5'd12, 32'h600, 32'h0, 6'd4, EW_16);
    check_models("zero_vl");
    check_count("zero_vl", "done pulses", d0 + 1, done_cnt);
  endtask

  initial begin
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = VLE;
    req_vd_i    = '0;
    req_rs1_i   = '0;
    req_rs2_i   = '0;
    req_vl_i    = '0;
    req_vsew_i  = EW_8;
    for (int a = 0; a < 4096; a++) mem[a] = 8'(a ^ (a >> 4) ^ 8'h5a);
    for (int a = 0; a < 256; a++) vrf[a] = {8'(a), ~8'(a), 8'(a * 5), 8'(a ^ 8'h96)};
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_unit_load();
    test_unit_store_partial();
    test_strided_load();
    test_strided_store();
    test_backpressure();
    test_zero_vl();
    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: files.f
rtl/vlsu_pkg.sv
rtl/vlsu_rob_if.sv
rtl/vlsu_ctrl.sv
rtl/vlsu_byte_counter.sv
rtl/vlsu_rob.sv
rtl/vlsu_mem_issue.sv
rtl/vlsu_vrf_port.sv
rtl/vlsu_top.sv
bench/vlsu_chk.sv
bench/tb_vlsu.sv
